// File: hdl/perf_defines.svh
`ifndef PERF_DEFINES_SVH
`define PERF_DEFINES_SVH

`define PERF_CNT_W        64
`define PERF_WORD_W       32
`define PERF_TAG_W        16
`define PERF_LINES        32
`define PERF_TRACE_DEPTH  16
`define PERF_ENABLE_BIT   24    // count enable in comm_i

`define PERF_HALF_W       (`PERF_WORD_W / 2)
`define PERF_TRACKER_MARK 16'hE000    // upper half of a tracker record
`define PERF_CODE_COUNT   4'd12       // readout code for the trace count

`endif

// File: hdl/perf_pkg.sv
`include "perf_defines.svh"

package perf_pkg;

	typedef logic [`PERF_WORD_W-1:0] perf_word_t;
	typedef logic [`PERF_CNT_W-1:0] perf_cnt_t;
	typedef logic [`PERF_TAG_W-1:0] cache_tag_t;
	typedef logic [$clog2(`PERF_TRACE_DEPTH)-1:0] trace_idx_t;

	// value 3 is not listed, it reads as counters
	typedef enum logic [1:0] {
		MODE_COUNTERS = 2'd0,
		MODE_SAMPLER  = 2'd1,
		MODE_TRACKER  = 2'd2
	} monitor_mode_e;

	typedef enum logic {
		SMP_IDLE,
		SMP_ARMED
	} sampler_state_e;

	typedef struct packed {
		logic       valid;
		perf_word_t data;
	} trace_wr_t;

endpackage

// File: hdl/perf_event_counters.sv
`include "perf_defines.svh"

module perf_event_counters (
	input  logic                 clock_i,
	input  logic                 resetn_i,
	input  logic                 hit_i,
	input  logic                 miss_i,
	input  logic                 writeback_i,
	input  logic                 expired_i,
	input  logic                 defaulted_i,
	input  perf_pkg::perf_word_t comm_i,
	output perf_pkg::perf_cnt_t  hit_cnt_o,
	output perf_pkg::perf_cnt_t  miss_cnt_o,
	output perf_pkg::perf_cnt_t  wb_cnt_o,
	output perf_pkg::perf_cnt_t  expired_cnt_o,
	output perf_pkg::perf_cnt_t  defaulted_cnt_o,
	output perf_pkg::perf_cnt_t  walltime_cnt_o
);

	import perf_pkg::*;

	localparam int N_CNT = 6;

	logic             count_en;
	logic [N_CNT-1:0] strobe;
	perf_cnt_t        cnt_q [N_CNT];

	assign count_en = comm_i[`PERF_ENABLE_BIT];

	// index order: hit, miss, wb, expired, defaulted, walltime
	assign strobe = {
		1'b1,            // wall time counts every enabled cycle
		defaulted_i,
		expired_i,
		writeback_i,
		miss_i,
		hit_i
	};

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < N_CNT; i++) begin
				cnt_q[i] <= '0;
			end
		end else if (count_en) begin
			for (int i = 0; i < N_CNT; i++) begin
				if (strobe[i]) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	assign hit_cnt_o       = cnt_q[0];
	assign miss_cnt_o      = cnt_q[1];
	assign wb_cnt_o        = cnt_q[2];
	assign expired_cnt_o   = cnt_q[3];
	assign defaulted_cnt_o = cnt_q[4];
	assign walltime_cnt_o  = cnt_q[5];

endmodule

// File: hdl/reuse_sampler.sv
`include "perf_defines.svh"

module reuse_sampler (
	input  logic                 clock_i,
	input  logic                 resetn_i,
	input  logic                 en_i,
	input  logic                 req_i,
	input  perf_pkg::cache_tag_t tag_ref_i,
	input  logic                 grant_i,
	output perf_pkg::trace_wr_t  wr_o
);

	import perf_pkg::*;

	sampler_state_e           state_q;
	cache_tag_t               armed_tag_q;
	logic [`PERF_HALF_W-1:0]  interval_q;
	trace_wr_t                wr_q;
	logic                     take_req;
	logic                     tag_match;

	assign take_req  = req_i & en_i & ~wr_q.valid;    // dropped while a record waits
	assign tag_match = take_req & (tag_ref_i == armed_tag_q);

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q    <= SMP_IDLE;
			interval_q <= '0;
			wr_q.valid <= 1'b0;
		end else begin
			if (grant_i) begin
				wr_q.valid <= 1'b0;
			end
			case (state_q)
				SMP_IDLE: begin
					if (take_req) begin
						armed_tag_q <= tag_ref_i;
						interval_q  <= 1;    // one edge apart on the next cycle
						state_q     <= SMP_ARMED;
					end
				end
				SMP_ARMED: begin
					if (tag_match) begin
						wr_q.valid <= 1'b1;
						wr_q.data  <= {armed_tag_q, interval_q};
						state_q    <= SMP_IDLE;
					end else if (interval_q != '1) begin
						interval_q <= interval_q + 1'b1;    // saturates at 0xffff
					end
				end
			endcase
		end
	end

	assign wr_o = wr_q;

endmodule

// File: hdl/expiry_tracker.sv
`include "perf_defines.svh"

module expiry_tracker (
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    en_i,
	input  logic                    req_i,
	input  logic [`PERF_LINES-1:0]  expired_flags_i,
	input  logic                    grant_i,
	output perf_pkg::trace_wr_t     wr_o
);

	import perf_pkg::*;

	localparam int ONES_W = $clog2(`PERF_LINES) + 1;    // holds 0 to PERF_LINES

	logic [ONES_W-1:0] ones;
	trace_wr_t         wr_q;

	// population count of the expired lines
	always_comb begin
		ones = '0;
		for (int i = 0; i < `PERF_LINES; i++) begin
			ones = ones + ONES_W'(expired_flags_i[i]);
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_q.valid <= 1'b0;
		end else begin
			if (grant_i) begin
				wr_q.valid <= 1'b0;
			end
			if (req_i && en_i && !wr_q.valid) begin
				wr_q.valid <= 1'b1;
				wr_q.data  <= {`PERF_TRACKER_MARK, {(`PERF_HALF_W - ONES_W){1'b0}}, ones};
			end
		end
	end

	assign wr_o = wr_q;

endmodule

// File: hdl/trace_arbiter.sv
`include "perf_defines.svh"

module trace_arbiter (
	input  logic                                clock_i,
	input  logic                                resetn_i,
	input  perf_pkg::trace_wr_t                 tracker_wr_i,
	input  perf_pkg::trace_wr_t                 sampler_wr_i,
	output logic                                tracker_grant_o,
	output logic                                sampler_grant_o,
	input  perf_pkg::trace_idx_t                rd_idx_i,
	output perf_pkg::perf_word_t                rd_data_o,
	output logic                                full_o,
	output logic [$clog2(`PERF_TRACE_DEPTH):0]  count_o
);

	import perf_pkg::*;

	perf_word_t mem_q [`PERF_TRACE_DEPTH];
	trace_idx_t wr_ptr_q;
	logic       full_q;
	logic       wr_en;
	perf_word_t wr_data;

	// tracker wins, nothing granted once full
	assign tracker_grant_o = tracker_wr_i.valid & ~full_q;
	assign sampler_grant_o = sampler_wr_i.valid & ~tracker_wr_i.valid & ~full_q;

	assign wr_en   = tracker_grant_o | sampler_grant_o;
	assign wr_data = tracker_grant_o ? tracker_wr_i.data : sampler_wr_i.data;

	always_ff @(posedge clock_i) begin
		if (wr_en) begin
			mem_q[wr_ptr_q] <= wr_data;
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			full_q   <= 1'b0;
		end else if (wr_en) begin
			wr_ptr_q <= wr_ptr_q + 1'b1;    // wraps to 0 on the last entry
			if (wr_ptr_q == trace_idx_t'(`PERF_TRACE_DEPTH - 1)) begin
				full_q <= 1'b1;
			end
		end
	end

	assign rd_data_o = mem_q[rd_idx_i];
	assign full_o    = full_q;
	assign count_o   = {full_q, wr_ptr_q};    // reads 16 when full

endmodule

// File: hdl/perf_readout.sv
`include "perf_defines.svh"

module perf_readout (
	input  logic                                clock_i,
	input  logic                                resetn_i,
	input  perf_pkg::monitor_mode_e             select_i,
	input  perf_pkg::perf_word_t                comm_i,
	input  perf_pkg::perf_cnt_t                 hit_cnt_i,
	input  perf_pkg::perf_cnt_t                 miss_cnt_i,
	input  perf_pkg::perf_cnt_t                 wb_cnt_i,
	input  perf_pkg::perf_cnt_t                 expired_cnt_i,
	input  perf_pkg::perf_cnt_t                 defaulted_cnt_i,
	input  perf_pkg::perf_cnt_t                 walltime_cnt_i,
	input  perf_pkg::perf_word_t                trace_data_i,
	input  logic                                trace_full_i,
	input  logic [$clog2(`PERF_TRACE_DEPTH):0]  trace_count_i,
	output perf_pkg::trace_idx_t                trace_idx_o,
	output logic                                sampler_en_o,
	output logic                                tracker_en_o,
	output logic                                stall_o,
	output perf_pkg::perf_word_t                comm_o
);

	import perf_pkg::*;

	perf_word_t cnt_slice;

	assign sampler_en_o = (select_i == MODE_SAMPLER);
	assign tracker_en_o = (select_i == MODE_TRACKER);
	assign stall_o      = trace_full_i & (sampler_en_o | tracker_en_o);
	assign trace_idx_o  = comm_i[$bits(trace_idx_t)-1:0];

	always_comb begin
		case (comm_i[3:0])
			4'd0:  cnt_slice = hit_cnt_i[`PERF_WORD_W-1:0];
			4'd1:  cnt_slice = hit_cnt_i[`PERF_CNT_W-1:`PERF_WORD_W];
			4'd2:  cnt_slice = miss_cnt_i[`PERF_WORD_W-1:0];
			4'd3:  cnt_slice = miss_cnt_i[`PERF_CNT_W-1:`PERF_WORD_W];
			4'd4:  cnt_slice = wb_cnt_i[`PERF_WORD_W-1:0];
			4'd5:  cnt_slice = wb_cnt_i[`PERF_CNT_W-1:`PERF_WORD_W];
			4'd6:  cnt_slice = walltime_cnt_i[`PERF_WORD_W-1:0];    // cycles enabled
			4'd7:  cnt_slice = walltime_cnt_i[`PERF_CNT_W-1:`PERF_WORD_W];
			4'd8:  cnt_slice = expired_cnt_i[`PERF_WORD_W-1:0];
			4'd9:  cnt_slice = expired_cnt_i[`PERF_CNT_W-1:`PERF_WORD_W];
			4'd10: cnt_slice = defaulted_cnt_i[`PERF_WORD_W-1:0];
			4'd11: cnt_slice = defaulted_cnt_i[`PERF_CNT_W-1:`PERF_WORD_W];
			`PERF_CODE_COUNT: cnt_slice = perf_word_t'(trace_count_i);
			default: cnt_slice = '0;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			comm_o <= '0;
		end else begin
			comm_o <= (sampler_en_o | tracker_en_o) ? trace_data_i : cnt_slice;
		end
	end

endmodule

// File: hdl/perf_monitor_top.sv
`include "perf_defines.svh"

module perf_monitor_top (
	input  logic                     clock_i,
	input  logic                     resetn_i,
	input  logic                     hit_i,
	input  logic                     miss_i,
	input  logic                     writeback_i,
	input  logic                     expired_i,
	input  logic                     defaulted_i,
	input  logic                     req_i,
	input  perf_pkg::cache_tag_t     tag_ref_i,
	input  logic [`PERF_LINES-1:0]   expired_flags_i,
	input  perf_pkg::perf_word_t     comm_i,
	input  perf_pkg::monitor_mode_e  select_i,
	output perf_pkg::perf_word_t     comm_o,
	output logic                     stall_o
);

	import perf_pkg::*;

	perf_cnt_t  hit_cnt, miss_cnt, wb_cnt, expired_cnt, defaulted_cnt, walltime_cnt;
	trace_wr_t  sampler_wr, tracker_wr;
	logic       sampler_grant, tracker_grant;
	logic       sampler_en, tracker_en;
	trace_idx_t trace_idx;
	perf_word_t trace_data;
	logic       trace_full;
	logic [$clog2(`PERF_TRACE_DEPTH):0] trace_count;

	perf_event_counters u_counters (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.hit_i           (hit_i),
		.miss_i          (miss_i),
		.writeback_i     (writeback_i),
		.expired_i       (expired_i),
		.defaulted_i     (defaulted_i),
		.comm_i          (comm_i),
		.hit_cnt_o       (hit_cnt),
		.miss_cnt_o      (miss_cnt),
		.wb_cnt_o        (wb_cnt),
		.expired_cnt_o   (expired_cnt),
		.defaulted_cnt_o (defaulted_cnt),
		.walltime_cnt_o  (walltime_cnt)
	);

	reuse_sampler u_sampler (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.en_i      (sampler_en),
		.req_i     (req_i),
		.tag_ref_i (tag_ref_i),
		.grant_i   (sampler_grant),
		.wr_o      (sampler_wr)
	);

	expiry_tracker u_tracker (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.en_i            (tracker_en),
		.req_i           (req_i),
		.expired_flags_i (expired_flags_i),
		.grant_i         (tracker_grant),
		.wr_o            (tracker_wr)
	);

	trace_arbiter u_arbiter (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.tracker_wr_i    (tracker_wr),
		.sampler_wr_i    (sampler_wr),
		.tracker_grant_o (tracker_grant),
		.sampler_grant_o (sampler_grant),
		.rd_idx_i        (trace_idx),
		.rd_data_o       (trace_data),
		.full_o          (trace_full),
		.count_o         (trace_count)
	);

	perf_readout u_readout (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.select_i        (select_i),
		.comm_i          (comm_i),
		.hit_cnt_i       (hit_cnt),
		.miss_cnt_i      (miss_cnt),
		.wb_cnt_i        (wb_cnt),
		.expired_cnt_i   (expired_cnt),
		.defaulted_cnt_i (defaulted_cnt),
		.walltime_cnt_i  (walltime_cnt),
		.trace_data_i    (trace_data),
		.trace_full_i    (trace_full),
		.trace_count_i   (trace_count),
		.trace_idx_o     (trace_idx),
		.sampler_en_o    (sampler_en),
		.tracker_en_o    (tracker_en),
		.stall_o         (stall_o),
		.comm_o          (comm_o)
	);

endmodule

// File: test/perf_checker.sv
module perf_checker (
	input  logic                 clock_i,
	input  perf_pkg::perf_word_t comm_i,
	input  logic                 stall_i,
	input  logic                 check_i,
	input  perf_pkg::perf_word_t exp_lo_i,
	input  perf_pkg::perf_word_t exp_hi_i,
	input  logic                 exp_stall_i,
	output int                   checks_o,
	output int                   errors_o
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		checks_o = 0;
		errors_o = 0;
	end

	// sample mid cycle, well away from the drive and capture edges
	always @(negedge clock_i) begin
		if (check_i === 1'b1) begin
			checks_o = checks_o + 1;
			if ($isunknown(comm_i) || comm_i < exp_lo_i || comm_i > exp_hi_i) begin
				errors_o = errors_o + 1;
				if (exp_lo_i == exp_hi_i) begin
					$display("error %0t: comm_o = 0x%08h, expected 0x%08h",
						$time, comm_i, exp_lo_i);
				end else begin
					$display("error %0t: comm_o = 0x%08h, expected 0x%08h to 0x%08h",
						$time, comm_i, exp_lo_i, exp_hi_i);
				end
			end
			if (stall_i !== exp_stall_i) begin
				errors_o = errors_o + 1;
				$display("error %0t: stall_o = %b, expected %b",
					$time, stall_i, exp_stall_i);
			end
		end
	end

endmodule

// File: test/tb_perf_monitor.sv
`include "perf_defines.svh"

module tb_perf_monitor;

	timeunit 1ns;
	timeprecision 100ps;

	import perf_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int RESET_CYCLES   = 5;
	localparam int STROBE_CYCLES  = 200;
	localparam int IDLE_CYCLES    = 50;
	localparam int SMP_MAX_CYCLES = 400;
	localparam int SMP_TARGET     = 8;    // leave room in the trace for the tracker
	localparam int TRK_MAX_CYCLES = 400;
	localparam int OVERRUN_CYCLES = 8;
	localparam int TRACE_DEPTH    = 16;
	localparam logic [15:0] TRACKER_MARK = 16'he000;
	localparam int RUN_CYCLES = RESET_CYCLES + STROBE_CYCLES + IDLE_CYCLES + 4 * 14
		+ SMP_MAX_CYCLES + 3 + 2 * TRACE_DEPTH + TRK_MAX_CYCLES + OVERRUN_CYCLES
		+ 2 * TRACE_DEPTH + 2 * 4 + 4;

	logic          clock;
	logic          resetn;
	logic          hit, miss, writeback, expired, defaulted;
	logic          req;
	cache_tag_t    tag_ref;
	logic [31:0]   expired_flags;
	perf_word_t    comm;
	monitor_mode_e select;
	perf_word_t    comm_out;
	logic          stall;

	logic          check;
	perf_word_t    exp_lo, exp_hi;
	logic          exp_stall;
	int            checks, mismatches;
	int            test_errors;

	logic [31:0]   lfsr_q;
	cache_tag_t    tag_set [4] = '{16'h1a2b, 16'h0042, 16'hbeef, 16'h7c00};

	// reference state
	perf_cnt_t     cnt_ref [6];    // hit, miss, wb, walltime, expired, defaulted
	perf_word_t    trace_ref [$];
	int            edge_no;
	logic          smp_armed, smp_pending, trk_pending;
	cache_tag_t    smp_tag;
	int            smp_arm_edge;
	perf_word_t    smp_record, trk_record;

	perf_monitor_top dut (
		.clock_i         (clock),
		.resetn_i        (resetn),
		.hit_i           (hit),
		.miss_i          (miss),
		.writeback_i     (writeback),
		.expired_i       (expired),
		.defaulted_i     (defaulted),
		.req_i           (req),
		.tag_ref_i       (tag_ref),
		.expired_flags_i (expired_flags),
		.comm_i          (comm),
		.select_i        (select),
		.comm_o          (comm_out),
		.stall_o         (stall)
	);

	perf_checker u_checker (
		.clock_i     (clock),
		.comm_i      (comm_out),
		.stall_i     (stall),
		.check_i     (check),
		.exp_lo_i    (exp_lo),
		.exp_hi_i    (exp_hi),
		.exp_stall_i (exp_stall),
		.checks_o    (checks),
		.errors_o    (mismatches)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD + 2000);
		$display("watchdog: the run did not finish within %0d cycles", RUN_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q  = lfsr_step(lfsr_q);
			bits[i] = lfsr_q[0];
		end
	endtask

	function automatic int ones_ref(input logic [31:0] f);
		int          n;
		logic [31:0] v;
		n = 0;
		v = f;
		while (v != 0) begin
			v = v & (v - 1);    // drop lowest set bit
			n++;
		end
		return n;
	endfunction

	function automatic perf_word_t comm_ref(input logic [1:0] mode, input logic [3:0] code);
		perf_cnt_t c;
		if (mode == 2'd1 || mode == 2'd2) begin
			return trace_ref[code];
		end
		if (code < 12) begin
			c = cnt_ref[code >> 1];
			return code[0] ? c[63:32] : c[31:0];
		end
		return (code == 12) ? perf_word_t'(trace_ref.size()) : '0;
	endfunction

	function automatic logic stall_ref(input logic [1:0] mode);
		return (trace_ref.size() >= TRACE_DEPTH) && (mode == 2'd1 || mode == 2'd2);
	endfunction

	// what the coming edge does with the inputs now driven
	task automatic model_edge();
		logic trk_take;
		logic smp_take;
		logic full_now;
		int   gap;
		full_now = (trace_ref.size() >= TRACE_DEPTH);
		trk_take = req && (select == MODE_TRACKER) && !trk_pending;
		smp_take = req && (select == MODE_SAMPLER) && !smp_pending;
		if (!full_now && trk_pending) begin    // tracker first
			trace_ref.push_back(trk_record);
			trk_pending = 1'b0;
		end else if (!full_now && smp_pending) begin
			trace_ref.push_back(smp_record);
			smp_pending = 1'b0;
		end
		if (trk_take) begin
			trk_pending = 1'b1;
			trk_record  = {TRACKER_MARK, 16'(ones_ref(expired_flags))};
		end
		if (smp_take && smp_armed && tag_ref == smp_tag) begin
			gap         = edge_no - smp_arm_edge;
			smp_pending = 1'b1;
			smp_record  = {smp_tag, (gap > 16'hffff) ? 16'hffff : 16'(gap)};
			smp_armed   = 1'b0;
		end else if (smp_take && !smp_armed) begin
			smp_armed    = 1'b1;
			smp_tag      = tag_ref;
			smp_arm_edge = edge_no;
		end
		if (comm[`PERF_ENABLE_BIT]) begin
			cnt_ref[0] = cnt_ref[0] + hit;
			cnt_ref[1] = cnt_ref[1] + miss;
			cnt_ref[2] = cnt_ref[2] + writeback;
			cnt_ref[3] = cnt_ref[3] + 1;    // wall time
			cnt_ref[4] = cnt_ref[4] + expired;
			cnt_ref[5] = cnt_ref[5] + defaulted;
		end
		edge_no++;
	endtask

	task automatic tick();
		model_edge();
		@(posedge clock);
		#10;
	endtask

	// one cycle to register comm_o and one to look at it
	task automatic read_check(input logic [1:0] mode, input logic [3:0] code, input int slack);
		select = monitor_mode_e'(mode);
		comm   = perf_word_t'(code);    // enable clear so the counters hold
		tick();
		exp_lo    = comm_ref(mode, code);
		exp_hi    = exp_lo + slack;
		exp_stall = stall_ref(mode);
		check     = 1'b1;
		tick();
		check = 1'b0;
	endtask

	task automatic read_all_counters();
		for (int code = 0; code < 14; code++) begin
			read_check(2'd0, 4'(code), (code == 6) ? 1 : 0);    // wall time low half
		end
	endtask

	initial begin
		logic [31:0] r;
		int          cycles;
		int          n_smp;
		lfsr_q = 32'h9ab052c8;
		{hit, miss, writeback, expired, defaulted} = '0;
		req = 1'b0;
		tag_ref = '0;
		expired_flags = '0;
		comm = '0;
		select = MODE_COUNTERS;
		resetn = 1'b0;
		check = 1'b0;
		exp_lo = '0;
		exp_hi = '0;
		exp_stall = 1'b0;
		test_errors = 0;
		foreach (cnt_ref[i]) cnt_ref[i] = '0;
		edge_no = 0;
		smp_armed = 1'b0;
		smp_pending = 1'b0;
		trk_pending = 1'b0;
		smp_tag = '0;
		smp_arm_edge = 0;
		smp_record = '0;
		trk_record = '0;

		repeat (RESET_CYCLES) @(posedge clock);
		#10;
		resetn = 1'b1;

		check = 1'b1;    // comm_o and stall_o straight out of reset
		tick();
		check = 1'b0;

		comm[`PERF_ENABLE_BIT] = 1'b1;
		repeat (STROBE_CYCLES) begin
			draw(5, r);
			{defaulted, expired, writeback, miss, hit} = r[4:0];
			tick();
		end
		comm = '0;
		{hit, miss, writeback, expired, defaulted} = '0;
		read_all_counters();

		repeat (IDLE_CYCLES) begin    // strobes with counting disabled
			draw(5, r);
			{defaulted, expired, writeback, miss, hit} = r[4:0];
			tick();
		end
		{hit, miss, writeback, expired, defaulted} = '0;
		read_all_counters();

		select = MODE_SAMPLER;
		cycles = 0;
		while (trace_ref.size() < SMP_TARGET && cycles < SMP_MAX_CYCLES) begin
			draw(1, r);
			req = r[0];
			draw(2, r);
			tag_ref = tag_set[r[1:0]];
			tick();
			cycles++;
		end
		req = 1'b0;
		if (trace_ref.size() < SMP_TARGET) begin
			test_errors++;
			$display("sampler wrote only %0d trace entries in %0d cycles",
				trace_ref.size(), cycles);
		end
		repeat (3) tick();    // let a pending record drain
		n_smp = trace_ref.size();
		for (int i = 0; i < n_smp; i++) begin
			read_check(2'd1, 4'(i), 0);
		end

		select = MODE_TRACKER;
		cycles = 0;
		while (trace_ref.size() < TRACE_DEPTH && cycles < TRK_MAX_CYCLES) begin
			draw(1, r);
			req = r[0];
			draw(32, r);
			expired_flags = r;
			tick();
			cycles++;
		end
		if (trace_ref.size() < TRACE_DEPTH) begin
			test_errors++;
			$display("trace did not fill in tracker mode, %0d entries", trace_ref.size());
		end
		repeat (OVERRUN_CYCLES) begin    // requests against a full trace are lost
			draw(1, r);
			req = r[0];
			draw(32, r);
			expired_flags = r;
			tick();
		end
		req = 1'b0;
		for (int i = 0; i < TRACE_DEPTH; i++) begin
			read_check(2'd2, 4'(i), 0);
		end

		read_check(2'd1, 4'd0, 0);
		read_check(2'd2, 4'd1, 0);
		read_check(2'd0, 4'd12, 0);
		read_check(2'd3, 4'd12, 0);    // mode 3 reads as counters

		$display("%0d mismatches in %0d checks, %0d other failures",
			mismatches, checks, test_errors);
		if (mismatches == 0 && test_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+hdl
hdl/perf_pkg.sv
hdl/perf_event_counters.sv
hdl/reuse_sampler.sv
hdl/expiry_tracker.sv
hdl/trace_arbiter.sv
hdl/perf_readout.sv
hdl/perf_monitor_top.sv
test/perf_checker.sv
test/tb_perf_monitor.sv

// File: Bender.yml
package:
  name: perf_monitor

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/perf_pkg.sv
      - hdl/perf_event_counters.sv
      - hdl/reuse_sampler.sv
      - hdl/expiry_tracker.sv
      - hdl/trace_arbiter.sv
      - hdl/perf_readout.sv
      - hdl/perf_monitor_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/perf_checker.sv
      - test/tb_perf_monitor.sv
